/* build.f */
common/matmul_pkg.sv
mem/tile_ram.sv
mem/matrix_banks.sv
engine/mac_row.sv
engine/mm_engine.sv
verilog/apb_config.sv
verilog/run_ctrl.sv
verilog/matmul_top.sv
verif/tb_matmul.sv

/* Makefile */
TOP = tb_matmul

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module matmul_top -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* verif/tb_matmul.sv */
`timescale 1ns/100ps

module tb_matmul import matmul_pkg::*; ();

  localparam int        MEM_DEPTH    = 256;
  localparam int        CLK_PERIOD   = 8;
  localparam int        RESET_CYCLES = 10;
  localparam reg_data_t START_WORD   = 32'h0000_0001;
  localparam reg_data_t CLEAR_WORD   = 32'h8000_0000;

  typedef enum logic [2:0] {
    OP_REG_WR,
    OP_REG_RD,
    OP_BANK_WR,
    OP_BANK_RD,
    OP_RUN,
    OP_CLEAR
  } op_t;

  // One table row, pdata is the expected value for register reads
  // and row is the expected value for bank reads
  typedef struct packed {
    op_t        kind;
    reg_addr_t  paddr;
    reg_data_t  pdata;
    bank_sel_t  sel;
    addr_t      baddr;
    row_t       row;
    lane_mask_t mask;
  } step_t;

  logic       clk = 1'b0;
  logic       PRESETn;
  reg_addr_t  PADDR;
  logic       PWRITE;
  logic       PSEL;
  logic       PENABLE;
  reg_data_t  PWDATA;
  reg_data_t  PRDATA;
  logic       PREADY;
  bank_sel_t  bram_select;
  addr_t      bram_addr_ext;
  row_t       bram_wdata_ext;
  lane_mask_t bram_we_ext;
  row_t       bram_rdata_ext;

  step_t steps[$];
  string step_names[$];
  row_t  a_rows[MAT_SIZE];
  row_t  b_rows[MAT_SIZE];
  int    cycle_count = 0;
  int    cycle_limit = 0;

  matmul_top #(
    .MEM_DEPTH (MEM_DEPTH)
  ) DUT (
    .clk            (clk),
    .PRESETn        (PRESETn),
    .PADDR          (PADDR),
    .PWRITE         (PWRITE),
    .PSEL           (PSEL),
    .PENABLE        (PENABLE),
    .PWDATA         (PWDATA),
    .PRDATA         (PRDATA),
    .PREADY         (PREADY),
    .bram_select    (bram_select),
    .bram_addr_ext  (bram_addr_ext),
    .bram_wdata_ext (bram_wdata_ext),
    .bram_we_ext    (bram_we_ext),
    .bram_rdata_ext (bram_rdata_ext)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Cycle budget, armed once the table is built
  always @(posedge clk) begin
    if (PRESETn) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $fatal(1, "cycle limit reached");
      end
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // C[i][j] is the sum over k of A[i][k] * B[k][j], kept modulo 256
  function automatic row_t model_c_row(input int i);
    row_t r;
    int   sum;
    r = '0;
    for (int j = 0; j < MAT_SIZE; j++) begin
      sum = 0;
      for (int k = 0; k < MAT_SIZE; k++) begin
        sum += int'(a_rows[i][k*DWIDTH +: DWIDTH]) * int'(b_rows[k][j*DWIDTH +: DWIDTH]);
      end
      r[j*DWIDTH +: DWIDTH] = data_t'(sum % 256);
    end
    return r;
  endfunction

  function automatic row_t merge_lanes(input row_t old_row, input row_t new_row,
                                       input lane_mask_t mask);
    row_t r;
    for (int l = 0; l < MAT_SIZE; l++) begin
      r[l*DWIDTH +: DWIDTH] = mask[l] ? new_row[l*DWIDTH +: DWIDTH]
                                      : old_row[l*DWIDTH +: DWIDTH];
    end
    return r;
  endfunction

  function automatic row_t address_fill(input addr_t a);
    return {a, ~a};
  endfunction

  //////////////////////////////
  // Table construction
  //////////////////////////////
  function automatic void add_step(input string name, input op_t kind, input reg_addr_t paddr,
                                   input reg_data_t pdata, input bank_sel_t sel,
                                   input addr_t baddr, input row_t row, input lane_mask_t mask);
    step_t s;
    s = '{kind, paddr, pdata, sel, baddr, row, mask};
    steps.push_back(s);
    step_names.push_back(name);
  endfunction

  function automatic void reg_write_op(input string name, input reg_addr_t a, input reg_data_t d);
    add_step(name, OP_REG_WR, a, d, '0, '0, '0, '0);
  endfunction

  function automatic void reg_read_op(input string name, input reg_addr_t a, input reg_data_t d);
    add_step(name, OP_REG_RD, a, d, '0, '0, '0, '0);
  endfunction

  function automatic void bank_write_op(input string name, input bank_sel_t sel, input addr_t a,
                                        input row_t d, input lane_mask_t mask);
    add_step(name, OP_BANK_WR, '0, '0, sel, a, d, mask);
  endfunction

  function automatic void bank_read_op(input string name, input bank_sel_t sel, input addr_t a,
                                       input row_t d);
    add_step(name, OP_BANK_RD, '0, '0, sel, a, d, '0);
  endfunction

  function automatic void build_table();
    reg_addr_t  map_addr[6];
    reg_data_t  value;
    row_t       old_row;
    row_t       new_row;
    row_t       keep_a;
    lane_mask_t mask;
    addr_t      c_at;
    map_addr = '{REG_ADDR_A, REG_ADDR_B, REG_ADDR_C, REG_STRIDE_A, REG_STRIDE_B, REG_STRIDE_C};
    keep_a   = '0;
    // Reset values
    reg_read_op("reset status", REG_CTRL_STATUS, 32'h0);
    for (int r = 0; r < 6; r++) begin
      reg_read_op($sformatf("reset reg %h", map_addr[r]), map_addr[r], (r < 3) ? 32'h0 : 32'h1);
    end
    reg_read_op("reset sink", 8'h00, 32'h0);
    // Fields hold 16 bits, then go back to the default layout
    for (int r = 0; r < 6; r++) begin
      value = $urandom();
      reg_write_op($sformatf("write reg %h", map_addr[r]), map_addr[r], value);
      reg_read_op($sformatf("readback reg %h", map_addr[r]), map_addr[r], {16'h0, value[15:0]});
      reg_write_op("restore default", map_addr[r], (r < 3) ? 32'h0 : 32'h1);
    end
    reg_write_op("write unmapped 0x40", 8'h40, 32'hcafe_f00d);
    reg_read_op("sink via 0x40", 8'h40, 32'hcafe_f00d);
    reg_read_op("sink via 0x7f", 8'h7f, 32'hcafe_f00d);
    reg_read_op("sink via 0x00", 8'h00, 32'hcafe_f00d);

    // External port with partial lane masks
    for (int s = 0; s < 3; s++) begin
      old_row = $urandom();
      new_row = $urandom();
      mask    = lane_mask_t'(5 + s);
      bank_write_op("bank full write", bank_sel_t'(s), addr_t'(16'h00F0 + s), old_row, '1);
      bank_write_op("bank masked write", bank_sel_t'(s), addr_t'(16'h00F0 + s), new_row, mask);
      bank_read_op($sformatf("bank %0d masked row", s), bank_sel_t'(s), addr_t'(16'h00F0 + s),
                   merge_lanes(old_row, new_row, mask));
      if (s == 0) begin
        keep_a = merge_lanes(old_row, new_row, mask);
      end
    end
    bank_write_op("select 3 write", 8'd3, 16'h00F0, ~keep_a, '1);
    bank_read_op("select 3 reads zero", 8'd3, 16'h00F0, '0);
    bank_read_op("bank A untouched by select 3", BANK_A, 16'h00F0, keep_a);

    // First run, default layout
    for (int i = 0; i < MAT_SIZE; i++) begin
      a_rows[i] = $urandom();
      b_rows[i] = $urandom();
      bank_write_op("load A", BANK_A, addr_t'(i), a_rows[i], '1);
      bank_write_op("load B", BANK_B, addr_t'(i), b_rows[i], '1);
    end
    add_step("default layout run", OP_RUN, '0, '0, '0, '0, '0, '0);
    for (int i = 0; i < MAT_SIZE; i++) begin
      bank_read_op($sformatf("run 1 C row %0d", i), BANK_C, addr_t'(i), model_c_row(i));
    end
    add_step("clear done", OP_CLEAR, '0, '0, '0, '0, '0, '0);
    reg_read_op("status after clear", REG_CTRL_STATUS, 32'h0);

    // Second run with moved bases and strides
    reg_write_op("set addr_a", REG_ADDR_A, 32'h40);
    reg_write_op("set addr_b", REG_ADDR_B, 32'h80);
    reg_write_op("set addr_c", REG_ADDR_C, 32'hA0);
    reg_write_op("set stride_a", REG_STRIDE_A, 32'h2);
    reg_write_op("set stride_c", REG_STRIDE_C, 32'h3);
    for (int off = 0; off < 3 * MAT_SIZE - 2; off++) begin
      bank_write_op("fill C", BANK_C, addr_t'(16'h00A0 + off),
                    address_fill(addr_t'(16'h00A0 + off)), '1);
    end
    for (int off = 1; off < 2 * MAT_SIZE - 1; off += 2) begin
      bank_write_op("fill A gap", BANK_A, addr_t'(16'h0040 + off),
                    address_fill(addr_t'(16'h0040 + off)), '1);
    end
    for (int i = 0; i < MAT_SIZE; i++) begin
      a_rows[i] = $urandom();
      b_rows[i] = $urandom();
      bank_write_op("load A strided", BANK_A, addr_t'(16'h0040 + 2 * i), a_rows[i], '1);
      bank_write_op("load B moved", BANK_B, addr_t'(16'h0080 + i), b_rows[i], '1);
    end
    add_step("strided run", OP_RUN, '0, '0, '0, '0, '0, '0);
    for (int off = 0; off < 3 * MAT_SIZE - 2; off++) begin
      c_at = addr_t'(16'h00A0 + off);
      if (off % 3 == 0) begin
        bank_read_op($sformatf("run 2 C row %0d", off / 3), BANK_C, c_at, model_c_row(off / 3));
      end else begin
        bank_read_op($sformatf("run 2 gap row %h", c_at), BANK_C, c_at, address_fill(c_at));
      end
    end
  endfunction

  //////////////////////////////
  // Bus drivers and checks
  //////////////////////////////
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Starts on a falling edge and returns on one
  task automatic apb_transfer(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                              output reg_data_t rdata);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = write;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge clk);
    // Bus is idle during the setup cycle
    check_value("PREADY low in setup cycle", 32'h0, {31'h0, PREADY});
    check_value("PRDATA zero in setup cycle", 32'h0, PRDATA);
    PENABLE = 1'b1;
    @(negedge clk);
    // PREADY answers on the edge that ends the access cycle
    check_value("PREADY after access cycle", 32'h1, {31'h0, PREADY});
    if (write) begin
      check_value("PRDATA zero on write", 32'h0, PRDATA);
    end
    rdata   = PRDATA;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
  endtask

  task automatic write_bank_row(input bank_sel_t sel, input addr_t a, input row_t d,
                                input lane_mask_t mask);
    bram_select    = sel;
    bram_addr_ext  = a;
    bram_wdata_ext = d;
    bram_we_ext    = mask;
    @(negedge clk);
    bram_we_ext = '0;
  endtask

  task automatic read_bank_row(input bank_sel_t sel, input addr_t a, output row_t q);
    bram_select   = sel;
    bram_addr_ext = a;
    bram_we_ext   = '0;
    @(negedge clk);
    q = bram_rdata_ext;
  endtask

  // Start, then poll status until done shows
  task automatic run_and_wait(input string name);
    reg_data_t status;
    apb_transfer(1'b1, REG_CTRL_STATUS, START_WORD, status);
    status = '0;
    while (!status[CTRL_DONE_BIT]) begin
      apb_transfer(1'b0, REG_CTRL_STATUS, '0, status);
    end
    check_value({name, " start bit at done"}, 32'h0, {31'h0, status[CTRL_START_BIT]});
  endtask

  task automatic apply_step(input step_t s, input string name);
    reg_data_t rdata;
    row_t      q;
    case (s.kind)
      OP_REG_WR: apb_transfer(1'b1, s.paddr, s.pdata, rdata);
      OP_REG_RD: begin
        apb_transfer(1'b0, s.paddr, '0, rdata);
        check_value(name, s.pdata, rdata);
      end
      OP_BANK_WR: write_bank_row(s.sel, s.baddr, s.row, s.mask);
      OP_BANK_RD: begin
        read_bank_row(s.sel, s.baddr, q);
        check_value(name, s.row, q);
      end
      OP_RUN: run_and_wait(name);
      OP_CLEAR: begin
        // Start must drop before the clear
        apb_transfer(1'b1, REG_CTRL_STATUS, '0, rdata);
        apb_transfer(1'b1, REG_CTRL_STATUS, CLEAR_WORD, rdata);
      end
      default: ;
    endcase
  endtask

  initial begin
    void'($urandom(32'hefd0_d822));
    PRESETn        = 1'b0;
    PADDR          = '0;
    PWRITE         = 1'b0;
    PSEL           = 1'b0;
    PENABLE        = 1'b0;
    PWDATA         = '0;
    bram_select    = '0;
    bram_addr_ext  = '0;
    bram_wdata_ext = '0;
    bram_we_ext    = '0;
    build_table();
    cycle_limit = 2 * (4 * steps.size() + 2 * 2 * MAT_SIZE * (MAT_SIZE + 4));
    repeat (RESET_CYCLES) @(negedge clk);
    PRESETn = 1'b1;
    for (int n = 0; n < steps.size(); n++) begin
      apply_step(steps[n], step_names[n]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

/* verilog/matmul_top.sv */
`timescale 1ns/100ps

module matmul_top import matmul_pkg::*; #(
  parameter int MEM_DEPTH = 256
) (
  input  logic       clk,
  input  logic       PRESETn,
  input  reg_addr_t  PADDR,
  input  logic       PWRITE,
  input  logic       PSEL,
  input  logic       PENABLE,
  input  reg_data_t  PWDATA,
  output reg_data_t  PRDATA,
  output logic       PREADY,
  input  bank_sel_t  bram_select,
  input  addr_t      bram_addr_ext,
  input  row_t       bram_wdata_ext,
  input  lane_mask_t bram_we_ext,
  output row_t       bram_rdata_ext
);

  mm_cfg_t cfg;
  logic    start_req;
  logic    clear_req;
  logic    start_mat_mul;
  logic    done_flag;
  logic    done_mat_mul;
  addr_t   a_addr;
  addr_t   b_addr;
  addr_t   c_addr;
  row_t    a_row;
  row_t    b_row;
  row_t    c_row;
  logic    c_we;

  apb_config u_apb_config (
    .clk           (clk),
    .PRESETn       (PRESETn),
    .PADDR         (PADDR),
    .PWRITE        (PWRITE),
    .PSEL          (PSEL),
    .PENABLE       (PENABLE),
    .PWDATA        (PWDATA),
    .start_mat_mul (start_mat_mul),
    .done_flag     (done_flag),
    .PRDATA        (PRDATA),
    .PREADY        (PREADY),
    .cfg           (cfg),
    .start_req     (start_req),
    .clear_req     (clear_req)
  );

  run_ctrl u_run_ctrl (
    .clk           (clk),
    .PRESETn       (PRESETn),
    .start_req     (start_req),
    .clear_req     (clear_req),
    .done_mat_mul  (done_mat_mul),
    .start_mat_mul (start_mat_mul),
    .done_flag     (done_flag)
  );

  matrix_banks #(
    .MEM_DEPTH (MEM_DEPTH)
  ) u_matrix_banks (
    .clk            (clk),
    .a_addr         (a_addr),
    .b_addr         (b_addr),
    .c_addr         (c_addr),
    .c_row          (c_row),
    .c_we           (c_we),
    .bram_select    (bram_select),
    .bram_addr_ext  (bram_addr_ext),
    .bram_wdata_ext (bram_wdata_ext),
    .bram_we_ext    (bram_we_ext),
    .a_row          (a_row),
    .b_row          (b_row),
    .bram_rdata_ext (bram_rdata_ext)
  );

  mm_engine u_mm_engine (
    .clk           (clk),
    .PRESETn       (PRESETn),
    .start_mat_mul (start_mat_mul),
    .cfg           (cfg),
    .a_row         (a_row),
    .b_row         (b_row),
    .done_mat_mul  (done_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .c_addr        (c_addr),
    .c_row         (c_row),
    .c_we          (c_we)
  );

endmodule

/* verilog/run_ctrl.sv */
`timescale 1ns/100ps

module run_ctrl import matmul_pkg::*; (
  input  logic clk,
  input  logic PRESETn,
  input  logic start_req,
  input  logic clear_req,
  input  logic done_mat_mul,
  output logic start_mat_mul,
  output logic done_flag
);

  run_state_t state;

  // Done stays visible until software clears it
  assign done_flag = (state == RUN_DONE);

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state         <= RUN_IDLE;
      start_mat_mul <= 1'b0;
    end else begin
      case (state)
        RUN_IDLE: begin
          start_mat_mul <= 1'b0;
          if (start_req) begin
            state <= RUN_LAUNCH;
          end
        end
        RUN_LAUNCH: begin
          start_mat_mul <= 1'b1;
          state         <= RUN_BUSY;
        end
        RUN_BUSY: begin
          if (done_mat_mul) begin
            start_mat_mul <= 1'b0;
            state         <= RUN_DONE;
          end
        end
        RUN_DONE: begin
          if (clear_req) begin
            state <= RUN_IDLE;
          end
        end
        default: state <= RUN_IDLE;
      endcase
    end
  end

endmodule

/* verilog/apb_config.sv */
`timescale 1ns/100ps

module apb_config import matmul_pkg::*; (
  input  logic      clk,
  input  logic      PRESETn,
  input  reg_addr_t PADDR,
  input  logic      PWRITE,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  reg_data_t PWDATA,
  input  logic      start_mat_mul,
  input  logic      done_flag,
  output reg_data_t PRDATA,
  output logic      PREADY,
  output mm_cfg_t   cfg,
  output logic      start_req,
  output logic      clear_req
);

  apb_state_t state;
  reg_data_t  sink_reg;
  reg_data_t  status_word;
  reg_data_t  rd_data;

  always_comb begin
    status_word = '0;
    status_word[CTRL_DONE_BIT]  = done_flag;
    status_word[CTRL_START_BIT] = start_mat_mul;
  end

  // Read mux, unmapped addresses fall back to the sink
  always_comb begin
    case (PADDR)
      REG_CTRL_STATUS: rd_data = status_word;
      REG_ADDR_A:      rd_data = reg_data_t'(cfg.addr_a);
      REG_ADDR_B:      rd_data = reg_data_t'(cfg.addr_b);
      REG_ADDR_C:      rd_data = reg_data_t'(cfg.addr_c);
      REG_STRIDE_A:    rd_data = reg_data_t'(cfg.stride_a);
      REG_STRIDE_B:    rd_data = reg_data_t'(cfg.stride_b);
      REG_STRIDE_C:    rd_data = reg_data_t'(cfg.stride_c);
      default:         rd_data = sink_reg;
    endcase
  end

  //////////////////////////////
  // Transfer FSM and registers
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state        <= APB_IDLE;
      PRDATA       <= '0;
      PREADY       <= 1'b0;
      cfg.addr_a   <= '0;
      cfg.addr_b   <= '0;
      cfg.addr_c   <= '0;
      cfg.stride_a <= stride_t'(1);
      cfg.stride_b <= stride_t'(1);
      cfg.stride_c <= stride_t'(1);
      start_req    <= 1'b0;
      clear_req    <= 1'b0;
      sink_reg     <= '0;
    end else begin
      // PREADY and PRDATA only live for one cycle
      PREADY <= 1'b0;
      PRDATA <= '0;
      case (state)
        APB_IDLE: begin
          if (PSEL) begin
            state <= PWRITE ? APB_WRITE : APB_READ;
          end
        end
        APB_WRITE: begin
          if (PSEL && PWRITE && PENABLE) begin
            case (PADDR)
              REG_CTRL_STATUS: begin
                start_req <= PWDATA[CTRL_START_BIT];
                clear_req <= PWDATA[CTRL_DONE_BIT];
              end
              REG_ADDR_A:   cfg.addr_a   <= addr_t'(PWDATA);
              REG_ADDR_B:   cfg.addr_b   <= addr_t'(PWDATA);
              REG_ADDR_C:   cfg.addr_c   <= addr_t'(PWDATA);
              REG_STRIDE_A: cfg.stride_a <= stride_t'(PWDATA);
              REG_STRIDE_B: cfg.stride_b <= stride_t'(PWDATA);
              REG_STRIDE_C: cfg.stride_c <= stride_t'(PWDATA);
              default:      sink_reg     <= PWDATA;
            endcase
            PREADY <= 1'b1;
          end
          state <= APB_IDLE;
        end
        APB_READ: begin
          if (PSEL && !PWRITE && PENABLE) begin
            PRDATA <= rd_data;
            PREADY <= 1'b1;
          end
          state <= APB_IDLE;
        end
        default: state <= APB_IDLE;
      endcase
    end
  end

endmodule

/* engine/mm_engine.sv */
`timescale 1ns/100ps

module mm_engine import matmul_pkg::*; (
  input  logic    clk,
  input  logic    PRESETn,
  input  logic    start_mat_mul,
  input  mm_cfg_t cfg,
  input  row_t    a_row,
  input  row_t    b_row,
  output logic    done_mat_mul,
  output addr_t   a_addr,
  output addr_t   b_addr,
  output addr_t   c_addr,
  output row_t    c_row,
  output logic    c_we
);

  localparam int CNT_W = $clog2(MAT_SIZE + 1);

  eng_state_t       state;
  logic [CNT_W-1:0] row_cnt;
  logic [CNT_W-1:0] mac_cnt;
  row_t             a_lat;
  logic             acc_clear;
  logic             acc_en;

  // Accumulate runs one cycle behind the B address
  assign acc_clear = (state == ENG_LOAD_A);
  assign acc_en    = (state == ENG_MAC) && (mac_cnt != '0);

  // A row is latched, then shifted down one element per step
  always_ff @(posedge clk) begin
    if (state == ENG_MAC) begin
      if (mac_cnt == '0) begin
        a_lat <= a_row;
      end else begin
        a_lat <= a_lat >> DWIDTH;
      end
    end
  end

  mac_row u_mac_row (
    .clk    (clk),
    .clear  (acc_clear),
    .enable (acc_en),
    .a_elem (a_lat[DWIDTH-1:0]),
    .b_row  (b_row),
    .c_row  (c_row)
  );

  //////////////////////////////
  // Row and column sequencing
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state        <= ENG_IDLE;
      row_cnt      <= '0;
      mac_cnt      <= '0;
      a_addr       <= '0;
      b_addr       <= '0;
      c_addr       <= '0;
      c_we         <= 1'b0;
      done_mat_mul <= 1'b0;
    end else begin
      case (state)
        ENG_IDLE: begin
          if (start_mat_mul) begin
            a_addr  <= cfg.addr_a;
            c_addr  <= cfg.addr_c;
            row_cnt <= '0;
            state   <= ENG_LOAD_A;
          end
        end
        ENG_LOAD_A: begin
          // A row address is on the bus this cycle
          b_addr  <= cfg.addr_b;
          mac_cnt <= '0;
          state   <= ENG_MAC;
        end
        ENG_MAC: begin
          b_addr  <= b_addr + cfg.stride_b;
          mac_cnt <= mac_cnt + 1'b1;
          if (mac_cnt == CNT_W'(MAT_SIZE)) begin
            c_we  <= 1'b1;
            state <= ENG_WRITE;
          end
        end
        ENG_WRITE: begin
          c_we   <= 1'b0;
          c_addr <= c_addr + cfg.stride_c;
          if (row_cnt == CNT_W'(MAT_SIZE - 1)) begin
            done_mat_mul <= 1'b1;
            state        <= ENG_FINISH;
          end else begin
            row_cnt <= row_cnt + 1'b1;
            a_addr  <= a_addr + cfg.stride_a;
            state   <= ENG_LOAD_A;
          end
        end
        ENG_FINISH: begin
          // Hold done until the run controller drops start
          if (!start_mat_mul) begin
            done_mat_mul <= 1'b0;
            state        <= ENG_IDLE;
          end
        end
        default: state <= ENG_IDLE;
      endcase
    end
  end

endmodule

/* engine/mac_row.sv */
`timescale 1ns/100ps

module mac_row import matmul_pkg::*; (
  input  logic  clk,
  input  logic  clear,
  input  logic  enable,
  input  data_t a_elem,
  input  row_t  b_row,
  output row_t  c_row
);

  acc_t acc [MAT_SIZE];

  // One accumulator per lane, clear wins over enable
  always_ff @(posedge clk) begin
    for (int l = 0; l < MAT_SIZE; l++) begin
      if (clear) begin
        acc[l] <= '0;
      end else if (enable) begin
        acc[l] <= acc[l] + acc_t'(a_elem) * acc_t'(b_row[l*DWIDTH +: DWIDTH]);
      end
    end
  end

  // C keeps only the low element bits
  always_comb begin
    for (int l = 0; l < MAT_SIZE; l++) begin
      c_row[l*DWIDTH +: DWIDTH] = acc[l][DWIDTH-1:0];
    end
  end

endmodule

/* mem/matrix_banks.sv */
`timescale 1ns/100ps

module matrix_banks import matmul_pkg::*; #(
  parameter int MEM_DEPTH = 256
) (
  input  logic       clk,
  input  addr_t      a_addr,
  input  addr_t      b_addr,
  input  addr_t      c_addr,
  input  row_t       c_row,
  input  logic       c_we,
  input  bank_sel_t  bram_select,
  input  addr_t      bram_addr_ext,
  input  row_t       bram_wdata_ext,
  input  lane_mask_t bram_we_ext,
  output row_t       a_row,
  output row_t       b_row,
  output row_t       bram_rdata_ext
);

  lane_mask_t we_a_ext;
  lane_mask_t we_b_ext;
  lane_mask_t we_c_ext;
  lane_mask_t we_c_eng;
  row_t       q_a_ext;
  row_t       q_b_ext;
  row_t       q_c_ext;
  bank_sel_t  sel_q;

  // External writes only reach the selected bank
  assign we_a_ext = (bram_select == BANK_A) ? bram_we_ext : '0;
  assign we_b_ext = (bram_select == BANK_B) ? bram_we_ext : '0;
  assign we_c_ext = (bram_select == BANK_C) ? bram_we_ext : '0;
  assign we_c_eng = {MAT_SIZE{c_we}};

  tile_ram #(.DEPTH(MEM_DEPTH)) u_bank_a (
    .clk(clk), .addr0(a_addr), .addr1(bram_addr_ext), .d0('0), .d1(bram_wdata_ext),
    .we0('0), .we1(we_a_ext), .q0(a_row), .q1(q_a_ext)
  );

  tile_ram #(.DEPTH(MEM_DEPTH)) u_bank_b (
    .clk(clk), .addr0(b_addr), .addr1(bram_addr_ext), .d0('0), .d1(bram_wdata_ext),
    .we0('0), .we1(we_b_ext), .q0(b_row), .q1(q_b_ext)
  );

  tile_ram #(.DEPTH(MEM_DEPTH)) u_bank_c (
    .clk(clk), .addr0(c_addr), .addr1(bram_addr_ext), .d0(c_row), .d1(bram_wdata_ext),
    .we0(we_c_eng), .we1(we_c_ext), .q0(), .q1(q_c_ext)
  );

  // Select follows the RAM read latency
  always_ff @(posedge clk) begin
    sel_q <= bram_select;
  end

  always_comb begin
    case (sel_q)
      BANK_A:  bram_rdata_ext = q_a_ext;
      BANK_B:  bram_rdata_ext = q_b_ext;
      BANK_C:  bram_rdata_ext = q_c_ext;
      default: bram_rdata_ext = '0;
    endcase
  end

endmodule

/* mem/tile_ram.sv */
`timescale 1ns/100ps

module tile_ram import matmul_pkg::*; #(
  parameter int DEPTH = 256
) (
  input  logic       clk,
  input  addr_t      addr0,
  input  addr_t      addr1,
  input  row_t       d0,
  input  row_t       d1,
  input  lane_mask_t we0,
  input  lane_mask_t we1,
  output row_t       q0,
  output row_t       q1
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  row_t             mem [DEPTH];
  logic [IDX_W-1:0] idx0;
  logic [IDX_W-1:0] idx1;

  // Row addresses wrap around the bank
  assign idx0 = IDX_W'(addr0 % DEPTH);
  assign idx1 = IDX_W'(addr1 % DEPTH);

  // Both ports read old data, port 1 wins on a same-row write
  always_ff @(posedge clk) begin
    for (int l = 0; l < MAT_SIZE; l++) begin
      if (we0[l]) begin
        mem[idx0][l*DWIDTH +: DWIDTH] <= d0[l*DWIDTH +: DWIDTH];
      end
      if (we1[l]) begin
        mem[idx1][l*DWIDTH +: DWIDTH] <= d1[l*DWIDTH +: DWIDTH];
      end
    end
    q0 <= mem[idx0];
    q1 <= mem[idx1];
  end

endmodule

/* common/matmul_pkg.sv */
package matmul_pkg;

  // Element width and tile dimension
  localparam int DWIDTH   = 8;
  localparam int MAT_SIZE = 4;

  typedef logic [DWIDTH-1:0]          data_t;
  typedef logic [2*DWIDTH+1:0]        acc_t;
  typedef logic [MAT_SIZE*DWIDTH-1:0] row_t;
  typedef logic [MAT_SIZE-1:0]        lane_mask_t;
  typedef logic [15:0]                addr_t;
  typedef logic [15:0]                stride_t;
  typedef logic [7:0]                 reg_addr_t;
  typedef logic [31:0]                reg_data_t;
  typedef logic [7:0]                 bank_sel_t;

  // Run configuration as seen by the engine
  typedef struct packed {
    addr_t   addr_a;
    addr_t   addr_b;
    addr_t   addr_c;
    stride_t stride_a;
    stride_t stride_b;
    stride_t stride_c;
  } mm_cfg_t;

  // External bank port select values
  localparam bank_sel_t BANK_A = 8'd0;
  localparam bank_sel_t BANK_B = 8'd1;
  localparam bank_sel_t BANK_C = 8'd2;

  // APB register map
  localparam reg_addr_t REG_CTRL_STATUS = 8'h04;
  localparam reg_addr_t REG_ADDR_A      = 8'h0E;
  localparam reg_addr_t REG_ADDR_B      = 8'h12;
  localparam reg_addr_t REG_ADDR_C      = 8'h16;
  localparam reg_addr_t REG_STRIDE_A    = 8'h28;
  localparam reg_addr_t REG_STRIDE_B    = 8'h32;
  localparam reg_addr_t REG_STRIDE_C    = 8'h03;

  // Control/status bit positions
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_DONE_BIT  = 31;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_WRITE,
    APB_READ
  } apb_state_t;

  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_LAUNCH,
    RUN_BUSY,
    RUN_DONE
  } run_state_t;

  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_LOAD_A,
    ENG_MAC,
    ENG_WRITE,
    ENG_FINISH
  } eng_state_t;

endpackage
